// File: hw/pad_pkg.sv
/* Shared types for the console pad path. Five multi-tap ports at most and
   indices past the last port read as an empty socket. */

`default_nettype none

package pad_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	// Ports on the multi-tap
	localparam int unsigned NUM_PORTS = 5;

	// Port counter wraps after 7, so 5..7 are empty sockets
	localparam int unsigned PORT_BITS = 3;

	localparam int unsigned PAD_WORD_BITS = 16;
	localparam int unsigned NIBBLE_BITS = 4;

	////////////////////////////////////////////////////////////////////////////
	// Host side
	////////////////////////////////////////////////////////////////////////////

	// Host gamepad, active high, right sits in bit 0
	typedef struct packed {
		logic b6;
		logic b5;
		logic b4;
		logic b3;
		logic run;
		logic select;
		logic b2;
		logic b1;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_buttons_t;

	////////////////////////////////////////////////////////////////////////////
	// Console side
	////////////////////////////////////////////////////////////////////////////

	// Console pad word, active low, one nibble per read
	typedef struct packed {
		logic [NIBBLE_BITS-1:0] id;       // always zero on a six-button pad
		logic [NIBBLE_BITS-1:0] extra;    // b6 b5 b4 b3
		logic [NIBBLE_BITS-1:0] dirs;     // left down right up
		logic [NIBBLE_BITS-1:0] buttons;  // run select b2 b1
	} pad_word_t;

	// Empty socket, every button released and id nibble low
	localparam pad_word_t NO_PAD_WORD = pad_word_t'({
		{NIBBLE_BITS{1'b0}},
		{(PAD_WORD_BITS - NIBBLE_BITS){1'b1}}
	});

	// Strobe lines owned by the console
	typedef struct packed {
		logic clr;
		logic sel;
	} pad_strobe_t;

	// Static options
	typedef struct packed {
		logic turbo_tap;   // multi-tap scan on sel edges
		logic six_button;  // clr edges toggle the extra phase
	} pad_config_t;

	// Field of the pad word returned; value is phase * 2 + sel
	typedef enum logic [1:0] {
		NIB_BUTTONS = 2'd0,
		NIB_DIRS    = 2'd1,
		NIB_EXTRA   = 2'd2,
		NIB_ID      = 2'd3
	} nibble_sel_t;

	// Nibble on the console data lines, active low
	typedef logic [NIBBLE_BITS-1:0] pad_nibble_t;

endpackage

`default_nettype wire

// File: hw/pad_encoder.sv
/* One host pad into the console word. The host pad is assumed already
   synchronous to clk_sys. */

`default_nettype none

module pad_encoder (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  pad_pkg::pad_buttons_t buttons,
	output pad_pkg::pad_word_t    word
);

	import pad_pkg::*;

	pad_word_t word_next;

	////////////////////////////////////////////////////////////////////////////
	// Remap host order to console order
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Top nibble low marks a six-button pad
		word_next.id = '0;

		word_next.extra = ~{
			buttons.b6,
			buttons.b5,
			buttons.b4,
			buttons.b3
		};

		// Console direction order differs from the host order
		word_next.dirs = ~{
			buttons.left,
			buttons.down,
			buttons.right,
			buttons.up
		};

		word_next.buttons = ~{
			buttons.run,
			buttons.select,
			buttons.b2,
			buttons.b1
		};
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	// Released until the first sample after reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			word <= NO_PAD_WORD;
		end else begin
			word <= word_next;
		end
	end

endmodule

`default_nettype wire

// File: hw/pad_scan_sequencer.sv
/* Strobes are plain levels sampled on clk_sys. Clear wins over a select edge,
   and the port only advances with the multi-tap enabled. */

`default_nettype none

module pad_scan_sequencer (
	input  wire                                 clk_sys,
	input  wire                                 reset,
	input  pad_pkg::pad_strobe_t                strobe,
	input  pad_pkg::pad_config_t                cfg,
	output logic [pad_pkg::PORT_BITS-1:0]       port_idx,
	output logic                                high_phase
);

	import pad_pkg::*;

	// Previous strobe sample
	pad_strobe_t strobe_q;

	logic clr_rise;
	logic sel_rise;

	logic [PORT_BITS-1:0] port_next;
	logic                 phase_next;

	////////////////////////////////////////////////////////////////////////////
	// Edge detect
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		strobe_q <= strobe;
	end

	assign clr_rise = strobe.clr & ~strobe_q.clr;
	assign sel_rise = strobe.sel & ~strobe_q.sel;

	////////////////////////////////////////////////////////////////////////////
	// Next port and phase
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		port_next = port_idx;
		phase_next = high_phase;

		if (strobe.clr) begin
			// Clear parks the scan on the first port
			port_next = '0;

			// Phase only toggles for six-button pads
			if (clr_rise) begin
				phase_next = ~high_phase & cfg.six_button;
			end
		end else if (sel_rise && cfg.turbo_tap) begin
			// Counter runs past the last port into the empty sockets
			port_next = port_idx + PORT_BITS'(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_idx <= '0;
			high_phase <= 1'b0;
		end else begin
			port_idx <= port_next;
			high_phase <= phase_next;
		end
	end

endmodule

`default_nettype wire

// File: hw/pad_nibble_select.sv
/* Returns one nibble of the addressed pad per clock. Ports past NUM_PORTS
   read as released, and clear forces the output low. */

`default_nettype none

module pad_nibble_select (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  pad_pkg::pad_word_t             words [pad_pkg::NUM_PORTS],
	input  wire [pad_pkg::PORT_BITS-1:0]   port_idx,
	input  wire                            high_phase,
	input  pad_pkg::pad_strobe_t           strobe,
	output pad_pkg::pad_nibble_t           nibble
);

	import pad_pkg::*;

	pad_word_t   addr_word;
	nibble_sel_t nib_sel;
	pad_nibble_t field;

	////////////////////////////////////////////////////////////////////////////
	// Addressed port
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Empty socket unless a port matches
		addr_word = NO_PAD_WORD;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (port_idx == PORT_BITS'(i)) begin
				addr_word = words[i];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Field pick
	////////////////////////////////////////////////////////////////////////////

	// Sel picks the half directly, without going through the sequencer
	assign nib_sel = nibble_sel_t'({high_phase, strobe.sel});

	always_comb begin
		unique case (nib_sel)
			NIB_BUTTONS: begin
				field = addr_word.buttons;
			end
			NIB_DIRS: begin
				field = addr_word.dirs;
			end
			NIB_EXTRA: begin
				field = addr_word.extra;
			end
			NIB_ID: begin
				field = addr_word.id;
			end
			default: begin
				field = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Output latch
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nibble <= '0;
		end else if (strobe.clr) begin
			// All lines low while the console holds clear
			nibble <= '0;
		end else begin
			nibble <= field;
		end
	end

endmodule

`default_nettype wire

// File: hw/pad_input_top.sv
/* Console pad input path with up to five multi-tap ports. No bus handshake;
   the console may read the nibble on any clock. */

`default_nettype none

module pad_input_top (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  pad_pkg::pad_buttons_t  pads [pad_pkg::NUM_PORTS],
	input  pad_pkg::pad_strobe_t   strobe,
	input  pad_pkg::pad_config_t   cfg,
	output pad_pkg::pad_nibble_t   nibble
);

	import pad_pkg::*;

	logic [PORT_BITS-1:0] port_idx;
	logic                 high_phase;
	pad_word_t            words [NUM_PORTS];

	////////////////////////////////////////////////////////////////////////////
	// Scan state
	////////////////////////////////////////////////////////////////////////////

	pad_scan_sequencer i_pad_scan_sequencer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.strobe     (strobe),
		.cfg        (cfg),
		.port_idx   (port_idx),
		.high_phase (high_phase)
	);

	////////////////////////////////////////////////////////////////////////////
	// One encoder per port
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_pad
		pad_encoder i_pad_encoder (
			.clk_sys (clk_sys),
			.reset   (reset),
			.buttons (pads[i]),
			.word    (words[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Nibble out
	////////////////////////////////////////////////////////////////////////////

	pad_nibble_select i_pad_nibble_select (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.words      (words),
		.port_idx   (port_idx),
		.high_phase (high_phase),
		.strobe     (strobe),
		.nibble     (nibble)
	);

endmodule

`default_nettype wire

// File: sim/pad_model.svh
/* Reference model for the pad nibble, included inside the testbench module
   after the pad_pkg import. Field layout follows the console word. */

`ifndef PAD_MODEL_SVH
`define PAD_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference
////////////////////////////////////////////////////////////////////////////

// Console word for one host pad, active low, top nibble zero
function automatic pad_word_t expected_word(input pad_buttons_t b);
	pad_word_t w;
	w = '0;
	w[0] = ~b.b1;
	w[1] = ~b.b2;
	w[2] = ~b.select;
	w[3] = ~b.run;
	w[4] = ~b.up;
	w[5] = ~b.right;
	w[6] = ~b.down;
	w[7] = ~b.left;
	w[8] = ~b.b3;
	w[9] = ~b.b4;
	w[10] = ~b.b5;
	w[11] = ~b.b6;
	return w;
endfunction

function automatic pad_nibble_t expected_nibble(
	input pad_buttons_t         pad_arr [NUM_PORTS],
	input logic [PORT_BITS-1:0] port,
	input logic                 phase,
	input logic                 sel,
	input logic                 clr
);
	pad_word_t w;
	if (clr) begin
		return '0;
	end
	// Empty sockets past the last port
	if (port < NUM_PORTS) begin
		w = expected_word(pad_arr[port]);
	end else begin
		w = NO_PAD_WORD;
	end
	case ({phase, sel})
		2'b00: return w[3:0];
		2'b01: return w[7:4];
		2'b10: return w[11:8];
		default: return w[15:12];
	endcase
endfunction

////////////////////////////////////////////////////////////////////////////
// Compare
////////////////////////////////////////////////////////////////////////////

task automatic check_nibble(input string name, input pad_nibble_t actual,
		input pad_nibble_t expected);
	if (actual !== expected) begin
		report_failure($sformatf("error at time %0t: %s expected %h, got %h",
			$time, name, expected, actual));
	end
endtask

task automatic check_port_word(input string name, input pad_word_t actual,
		input pad_word_t expected);
	if (actual !== expected) begin
		report_failure($sformatf("error at time %0t: %s expected %h, got %h",
			$time, name, expected, actual));
	end
endtask

`endif

// File: sim/pad_input_tb.sv
/* Self-checking testbench for the pad input path. Strobe levels are held at
   least three cycles so each change gives exactly one edge. */

`default_nettype none

module pad_input_tb;

	import pad_pkg::*;

	localparam int unsigned IDLE_LIMIT = 100;
	localparam int unsigned SETTLE_LIMIT = 20;

	logic         clk_sys;
	logic         reset;
	pad_buttons_t pads [NUM_PORTS];
	pad_strobe_t  strobe;
	pad_config_t  cfg;
	pad_nibble_t  nibble;

	// Testbench copy of the scan state
	logic [PORT_BITS-1:0] m_port;
	logic                 m_phase;

	int unsigned req_count;
	int unsigned done_count;
	pad_nibble_t seen_nibble;

	pad_input_top i_pad_input_top (
		.clk_sys (clk_sys),
		.reset   (reset),
		.pads    (pads),
		.strobe  (strobe),
		.cfg     (cfg),
		.nibble  (nibble)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	`include "pad_model.svh"

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_strobe(input logic clr, input logic sel);
		@(posedge clk_sys);
		#1;
		// Sequencer rules, clear before select
		if (clr) begin
			m_port = '0;
			if (!strobe.clr) begin
				m_phase = !m_phase && cfg.six_button;
			end
		end else if (sel && !strobe.sel && cfg.turbo_tap) begin
			m_port = m_port + PORT_BITS'(1);
		end
		strobe.clr = clr;
		strobe.sel = sel;
	endtask

	task automatic set_config(input logic turbo_tap, input logic six_button);
		@(posedge clk_sys);
		#1;
		cfg.turbo_tap = turbo_tap;
		cfg.six_button = six_button;
	endtask

	task automatic set_pad(input int idx);
		@(posedge clk_sys);
		#1;
		pads[idx] = 12'($urandom());
	endtask

	task automatic randomize_pads();
		@(posedge clk_sys);
		#1;
		for (int i = 0; i < NUM_PORTS; i++) begin
			pads[i] = 12'($urandom());
		end
	endtask

	// Hand one check to the compare process and wait for it
	task automatic settle_and_check();
		int waited;
		waited = 0;
		req_count++;
		while (done_count != req_count) begin
			@(posedge clk_sys);
			waited++;
			if (waited > SETTLE_LIMIT) begin
				report_failure("the nibble check did not complete in time");
			end
		end
	endtask

	task automatic pulse_clear();
		drive_strobe(1'b1, strobe.sel);
		settle_and_check();
		drive_strobe(1'b0, strobe.sel);
		settle_and_check();
	endtask

	// Four reads of port 0, needs six_button set and the low phase
	task automatic read_port0_word(output pad_word_t w);
		w = '0;
		drive_strobe(1'b0, 1'b0);
		settle_and_check();
		w[3:0] = seen_nibble;
		drive_strobe(1'b0, 1'b1);
		settle_and_check();
		w[7:4] = seen_nibble;
		// Clear with sel held high, so no select edge follows
		drive_strobe(1'b1, 1'b1);
		settle_and_check();
		drive_strobe(1'b0, 1'b1);
		settle_and_check();
		w[15:12] = seen_nibble;
		drive_strobe(1'b0, 1'b0);
		settle_and_check();
		w[11:8] = seen_nibble;
		// Back to the low phase
		pulse_clear();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////////////////////

	initial begin : compare_proc
		int idle;
		pad_nibble_t exp_nibble;
		forever begin
			idle = 0;
			while (req_count == done_count) begin
				@(posedge clk_sys);
				idle++;
				if (idle > IDLE_LIMIT) begin
					report_failure("no check was requested for too long");
				end
			end
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			exp_nibble = expected_nibble(pads, m_port, m_phase, strobe.sel, strobe.clr);
			check_nibble("nibble", nibble, exp_nibble);
			seen_nibble = nibble;
			done_count++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		pad_word_t   word_read;
		pad_nibble_t prev_nibble;
		void'($urandom(32'hd1d8));
		reset = 1'b1;
		strobe = '0;
		strobe.clr = 1'b1;
		cfg = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			pads[i] = '0;
		end
		m_port = '0;
		m_phase = 1'b0;
		req_count = 0;
		done_count = 0;
		seen_nibble = '0;
		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Clear held, nibble stays low
		settle_and_check();
		for (int k = 0; k < 4; k++) begin
			randomize_pads();
			settle_and_check();
		end

		// Plain two-button pad on port 0
		drive_strobe(1'b0, 1'b0);
		settle_and_check();
		for (int k = 0; k < 6; k++) begin
			randomize_pads();
			settle_and_check();
			drive_strobe(1'b0, 1'b1);
			settle_and_check();
			drive_strobe(1'b0, 1'b0);
			settle_and_check();
		end

		// Six-button phase and full word reads
		set_config(1'b0, 1'b1);
		pulse_clear();
		drive_strobe(1'b0, 1'b1);
		settle_and_check();
		drive_strobe(1'b0, 1'b0);
		settle_and_check();
		pulse_clear();
		for (int k = 0; k < 4; k++) begin
			randomize_pads();
			read_port0_word(word_read);
			check_port_word("port 0 word", word_read, expected_word(pads[0]));
		end
		set_config(1'b0, 1'b0);
		for (int k = 0; k < 2; k++) begin
			pulse_clear();
			drive_strobe(1'b0, 1'b1);
			settle_and_check();
			drive_strobe(1'b0, 1'b0);
			settle_and_check();
		end

		// Multi-tap scan through all eight indices
		set_config(1'b1, 1'b0);
		randomize_pads();
		pulse_clear();
		for (int step = 0; step < 8; step++) begin
			drive_strobe(1'b0, 1'b1);
			settle_and_check();
			drive_strobe(1'b0, 1'b0);
			settle_and_check();
		end
		pulse_clear();

		// Pad changes on the addressed port and on another one
		for (int step = 0; step < 2; step++) begin
			drive_strobe(1'b0, 1'b1);
			settle_and_check();
			drive_strobe(1'b0, 1'b0);
			settle_and_check();
		end
		for (int k = 0; k < 4; k++) begin
			set_pad(2);
			settle_and_check();
			prev_nibble = seen_nibble;
			set_pad(4);
			settle_and_check();
			check_nibble("nibble after other pad change", seen_nibble, prev_nibble);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: pad_input_top.f
+incdir+sim
hw/pad_pkg.sv
hw/pad_encoder.sv
hw/pad_scan_sequencer.sv
hw/pad_nibble_select.sv
hw/pad_input_top.sv
sim/pad_input_tb.sv

// File: Bender.yml
package:
  name: pad_input

sources:
  - files:
      - hw/pad_pkg.sv
      - hw/pad_encoder.sv
      - hw/pad_scan_sequencer.sv
      - hw/pad_nibble_select.sv
      - hw/pad_input_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/pad_input_tb.sv
